// File: Bender.yml
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/idu_2.sv
  - src/regfile.sv
  - src/alu.sv
  - src/pc_unit.sv
  - src/exec_sequencer.sv
  - src/mips_core.sv
  - target: simulation
    files:
      - tb/core_checker.sv
      - tb/tb_mips_core.sv

// File: mips_core.f
src/mips_pkg.sv
src/idu_2.sv
src/regfile.sv
src/alu.sv
src/pc_unit.sv
src/exec_sequencer.sv
src/mips_core.sv
tb/core_checker.sv
tb/tb_mips_core.sv

// File: src/alu.sv
`default_nettype none

module alu (
    input  var mips_pkg::alu_sel_t      alu_sel,
    input  var mips_pkg::src_b_sel_t    src_b_sel,
    input  wire [31:0]                  rs_data,
    input  wire [31:0]                  rt_data,
    input  wire [31:0]                  ext_imme,
    input  wire [4:0]                   sa,
    output logic [31:0]                 result
);

    logic        is_shift;
    logic [31:0] op_a;
    logic [31:0] op_b;

    assign is_shift = (alu_sel == mips_pkg::alu_sll) |
                      (alu_sel == mips_pkg::alu_srl) |
                      (alu_sel == mips_pkg::alu_sra);

    // shifts move rt, everything else works on rs
    assign op_a = is_shift ? rt_data : rs_data;

    always_comb begin
        case (src_b_sel)
            mips_pkg::src_b_imme: op_b = ext_imme;
            mips_pkg::src_b_sa:   op_b = {27'd0, sa};
            default:              op_b = rt_data;
        endcase
    end

    always_comb begin
        case (alu_sel)
            mips_pkg::alu_add:  result = op_a + op_b;
            mips_pkg::alu_sub:  result = op_a - op_b;
            mips_pkg::alu_and:  result = op_a & op_b;
            mips_pkg::alu_or:   result = op_a | op_b;
            mips_pkg::alu_xor:  result = op_a ^ op_b;
            mips_pkg::alu_nor:  result = ~(op_a | op_b);
            mips_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            mips_pkg::alu_sltu: result = {31'd0, op_a < op_b};
            mips_pkg::alu_sll:  result = op_a << op_b[4:0];
            mips_pkg::alu_srl:  result = op_a >> op_b[4:0];
            mips_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> op_b[4:0]);
            mips_pkg::alu_lui:  result = {op_b[15:0], 16'h0000};
            default:            result = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/exec_sequencer.sv
`default_nettype none

module exec_sequencer (
    input  wire                                 clk,
    input  wire                                 reset,

    input  wire                                 wb_cyc,
    input  wire                                 wb_stb,
    input  wire                                 wb_we,
    input  wire [mips_pkg::wb_adr_width-1:0]    wb_adr,
    input  wire [31:0]                          wb_dat_w,
    output logic [31:0]                         wb_dat_r,
    output logic                                wb_ack,

    output logic [31:0]                         instr,
    output logic                                exec_en,
    output logic [4:0]                          rd_addr,
    input  wire [31:0]                          rd_data,
    input  wire [31:0]                          pc
);

    typedef enum logic [1:0] {st_idle, st_decode, st_exec, st_ack} state_t;

    state_t state;
    logic   req;

    assign req     = wb_cyc & wb_stb;
    assign rd_addr = wb_adr[4:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        if (wb_we && (wb_adr == mips_pkg::adr_exec)) begin
                            state <= st_decode;
                        end else begin
                            state <= st_ack;
                        end
                    end
                end
                st_decode: state <= st_exec;
                st_exec:   state <= st_ack;
                default:   state <= st_idle;
            endcase
        end
    end

    // instruction and read-back data are captured on the request edge
    always_ff @(posedge clk) begin
        if ((state == st_idle) && req) begin
            if (wb_we) begin
                instr <= wb_dat_w;
            end else if (wb_adr[mips_pkg::wb_adr_width-1:5] == '0) begin
                wb_dat_r <= rd_data;
            end else if (wb_adr == mips_pkg::adr_pc) begin
                wb_dat_r <= pc;
            end else begin
                wb_dat_r <= 32'h0;
            end
        end
    end

    assign exec_en = (state == st_exec);
    assign wb_ack  = (state == st_ack);

endmodule

`default_nettype wire

// File: src/idu_2.sv
`default_nettype none

module idu_2 (
    input  wire [31:0]              instr,
    input  wire [31:0]              rs_data,
    input  wire [31:0]              rt_data,
    input  wire [31:0]              pc,

    output logic [4:0]              reg_r_addr_1,
    output logic [4:0]              reg_r_addr_2,

    output mips_pkg::alu_sel_t      alu_sel,
    output mips_pkg::src_b_sel_t    src_b_sel,
    output logic [31:0]             ext_imme,
    output logic [4:0]              sa,

    output logic                    w_reg_ena,
    output logic [4:0]              w_reg_dst,

    output logic                    take_branch,
    output logic [31:0]             branch_target
);

    logic [5:0]  op_code;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [5:0]  funct;
    logic [15:0] imme;
    logic [25:0] j_imme;
    logic        sign_ext;
    logic [31:0] pc_plus_4;
    logic [31:0] br_offset;

    assign op_code = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign sa      = instr[10:6];
    assign funct   = instr[5:0];
    assign imme    = instr[15:0];
    assign j_imme  = instr[25:0];

    assign reg_r_addr_1 = rs;
    assign reg_r_addr_2 = rt;

    assign sign_ext = (op_code == mips_pkg::op_addiu) |
                      (op_code == mips_pkg::op_slti)  |
                      (op_code == mips_pkg::op_sltiu);

    assign ext_imme = sign_ext ? {{16{imme[15]}}, imme} : {16'h0000, imme};

    always_comb begin
        alu_sel   = mips_pkg::alu_add;
        src_b_sel = mips_pkg::src_b_rt;
        w_reg_ena = 1'b0;
        w_reg_dst = rd;
        case (op_code)
            mips_pkg::op_special: begin
                w_reg_ena = 1'b1;
                case (funct)
                    mips_pkg::funct_addu: alu_sel = mips_pkg::alu_add;
                    mips_pkg::funct_subu: alu_sel = mips_pkg::alu_sub;
                    mips_pkg::funct_and:  alu_sel = mips_pkg::alu_and;
                    mips_pkg::funct_or:   alu_sel = mips_pkg::alu_or;
                    mips_pkg::funct_xor:  alu_sel = mips_pkg::alu_xor;
                    mips_pkg::funct_nor:  alu_sel = mips_pkg::alu_nor;
                    mips_pkg::funct_slt:  alu_sel = mips_pkg::alu_slt;
                    mips_pkg::funct_sltu: alu_sel = mips_pkg::alu_sltu;
                    mips_pkg::funct_sll: begin
                        alu_sel   = mips_pkg::alu_sll;
                        src_b_sel = mips_pkg::src_b_sa;
                    end
                    mips_pkg::funct_srl: begin
                        alu_sel   = mips_pkg::alu_srl;
                        src_b_sel = mips_pkg::src_b_sa;
                    end
                    mips_pkg::funct_sra: begin
                        alu_sel   = mips_pkg::alu_sra;
                        src_b_sel = mips_pkg::src_b_sa;
                    end
                    // unknown funct is a no-op
                    default: w_reg_ena = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: alu_sel = mips_pkg::alu_add;
            mips_pkg::op_slti:  alu_sel = mips_pkg::alu_slt;
            mips_pkg::op_sltiu: alu_sel = mips_pkg::alu_sltu;
            mips_pkg::op_andi:  alu_sel = mips_pkg::alu_and;
            mips_pkg::op_ori:   alu_sel = mips_pkg::alu_or;
            mips_pkg::op_xori:  alu_sel = mips_pkg::alu_xor;
            mips_pkg::op_lui:   alu_sel = mips_pkg::alu_lui;
            default: ;
        endcase

        // immediate forms write rt
        if (op_code[5:3] == 3'b001) begin
            src_b_sel = mips_pkg::src_b_imme;
            w_reg_ena = (op_code != 6'h08);
            w_reg_dst = rt;
        end
    end

    assign pc_plus_4 = pc + 32'd4;
    assign br_offset = {{14{imme[15]}}, imme, 2'b00};

    assign take_branch =
        ((op_code == mips_pkg::op_beq)  & (rs_data == rt_data))           |
        ((op_code == mips_pkg::op_bne)  & (rs_data != rt_data))           |
        ((op_code == mips_pkg::op_bgtz) & ($signed(rs_data) >  32'sd0))   |
        ((op_code == mips_pkg::op_blez) & ($signed(rs_data) <= 32'sd0))   |
        (op_code == mips_pkg::op_j);

    assign branch_target = (op_code == mips_pkg::op_j) ?
                           {pc_plus_4[31:28], j_imme, 2'b00} :
                           pc_plus_4 + br_offset;

endmodule

`default_nettype wire

// File: src/mips_core.sv
`default_nettype none

module mips_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire                                 clk,
    input  wire                                 reset,

    input  wire                                 wb_cyc,
    input  wire                                 wb_stb,
    input  wire                                 wb_we,
    input  wire [mips_pkg::wb_adr_width-1:0]    wb_adr,
    input  wire [31:0]                          wb_dat_w,
    output logic [31:0]                         wb_dat_r,
    output logic                                wb_ack
);

    logic [31:0]            instr;
    logic                   exec_en;
    logic [4:0]             rd_addr;
    logic [31:0]            rd_data;
    logic [31:0]            pc;

    logic [4:0]             reg_r_addr_1;
    logic [4:0]             reg_r_addr_2;
    logic [31:0]            rs_data;
    logic [31:0]            rt_data;

    mips_pkg::alu_sel_t     alu_sel;
    mips_pkg::src_b_sel_t   src_b_sel;
    logic [31:0]            ext_imme;
    logic [4:0]             sa;
    logic [31:0]            result;

    logic                   w_reg_ena;
    logic [4:0]             w_reg_dst;
    logic                   w_ena;
    logic                   take_branch;
    logic [31:0]            branch_target;

    // writeback only during the exec cycle
    assign w_ena = exec_en & w_reg_ena;

    exec_sequencer exec_sequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .instr      (instr),
        .exec_en    (exec_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pc         (pc)
    );

    idu_2 idu_2_inst (
        .instr          (instr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .pc             (pc),
        .reg_r_addr_1   (reg_r_addr_1),
        .reg_r_addr_2   (reg_r_addr_2),
        .alu_sel        (alu_sel),
        .src_b_sel      (src_b_sel),
        .ext_imme       (ext_imme),
        .sa             (sa),
        .w_reg_ena      (w_reg_ena),
        .w_reg_dst      (w_reg_dst),
        .take_branch    (take_branch),
        .branch_target  (branch_target)
    );

    regfile regfile_inst (
        .clk        (clk),
        .reset      (reset),
        .r_addr_1   (reg_r_addr_1),
        .r_addr_2   (reg_r_addr_2),
        .r_addr_3   (rd_addr),
        .r_data_1   (rs_data),
        .r_data_2   (rt_data),
        .r_data_3   (rd_data),
        .w_ena      (w_ena),
        .w_addr     (w_reg_dst),
        .w_data     (result)
    );

    alu alu_inst (
        .alu_sel    (alu_sel),
        .src_b_sel  (src_b_sel),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .ext_imme   (ext_imme),
        .sa         (sa),
        .result     (result)
    );

    pc_unit #(
        .reset_pc   (reset_pc)
    ) pc_unit_inst (
        .clk            (clk),
        .reset          (reset),
        .step           (exec_en),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .pc             (pc)
    );

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int op_width    = 6;
    localparam int funct_width = 6;

    // primary opcodes, instr[31:26]
    localparam logic [op_width-1:0] op_special = 6'h00;
    localparam logic [op_width-1:0] op_j       = 6'h02;
    localparam logic [op_width-1:0] op_beq     = 6'h04;
    localparam logic [op_width-1:0] op_bne     = 6'h05;
    localparam logic [op_width-1:0] op_blez    = 6'h06;
    localparam logic [op_width-1:0] op_bgtz    = 6'h07;
    localparam logic [op_width-1:0] op_addiu   = 6'h09;
    localparam logic [op_width-1:0] op_slti    = 6'h0a;
    localparam logic [op_width-1:0] op_sltiu   = 6'h0b;
    localparam logic [op_width-1:0] op_andi    = 6'h0c;
    localparam logic [op_width-1:0] op_ori     = 6'h0d;
    localparam logic [op_width-1:0] op_xori    = 6'h0e;
    localparam logic [op_width-1:0] op_lui     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [funct_width-1:0] funct_sll  = 6'h00;
    localparam logic [funct_width-1:0] funct_srl  = 6'h02;
    localparam logic [funct_width-1:0] funct_sra  = 6'h03;
    localparam logic [funct_width-1:0] funct_addu = 6'h21;
    localparam logic [funct_width-1:0] funct_subu = 6'h23;
    localparam logic [funct_width-1:0] funct_and  = 6'h24;
    localparam logic [funct_width-1:0] funct_or   = 6'h25;
    localparam logic [funct_width-1:0] funct_xor  = 6'h26;
    localparam logic [funct_width-1:0] funct_nor  = 6'h27;
    localparam logic [funct_width-1:0] funct_slt  = 6'h2a;
    localparam logic [funct_width-1:0] funct_sltu = 6'h2b;

    localparam int alu_sel_width   = 4;
    localparam int src_b_sel_width = 2;

    typedef enum logic [alu_sel_width-1:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_sel_t;

    typedef enum logic [src_b_sel_width-1:0] {
        src_b_rt, src_b_imme, src_b_sa
    } src_b_sel_t;

    localparam int wb_adr_width = 8;

    // register window sits at 0x00..0x1f
    localparam logic [wb_adr_width-1:0] adr_exec = 8'h40;
    localparam logic [wb_adr_width-1:0] adr_pc   = 8'h20;

endpackage

`default_nettype wire

// File: src/pc_unit.sv
`default_nettype none

module pc_unit #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         step,
    input  wire         take_branch,
    input  wire [31:0]  branch_target,
    output logic [31:0] pc
);

    // no delay slot, a taken target replaces pc+4
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (step) begin
            if (take_branch) begin
                pc <= branch_target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire         reset,

    input  wire [4:0]   r_addr_1,
    input  wire [4:0]   r_addr_2,
    input  wire [4:0]   r_addr_3,
    output logic [31:0] r_data_1,
    output logic [31:0] r_data_2,
    output logic [31:0] r_data_3,

    input  wire         w_ena,
    input  wire [4:0]   w_addr,
    input  wire [31:0]  w_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (w_ena && (w_addr != 5'd0)) begin
            regs[w_addr] <= w_data;
        end
    end

    // $zero is hardwired
    assign r_data_1 = (r_addr_1 == 5'd0) ? 32'h0 : regs[r_addr_1];
    assign r_data_2 = (r_addr_2 == 5'd0) ? 32'h0 : regs[r_addr_2];
    assign r_data_3 = (r_addr_3 == 5'd0) ? 32'h0 : regs[r_addr_3];

endmodule

`default_nettype wire

// File: tb/core_checker.sv
`default_nettype none

module core_checker #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 wb_cyc,
    input  wire                                 wb_stb,
    input  wire                                 wb_we,
    input  wire [mips_pkg::wb_adr_width-1:0]    wb_adr,
    input  wire [31:0]                          wb_dat_w,
    input  wire [31:0]                          wb_dat_r,
    input  wire                                 wb_ack,
    output int                                  error_count
);

    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] expected;
    logic        after_reset;

    function automatic logic [31:0] read_model(input logic [7:0] adr);
        if (adr < 8'h20) begin
            return regs[adr[4:0]];
        end
        return (adr == mips_pkg::adr_pc) ? pc : 32'h0;
    endfunction

    task automatic apply_instr(input logic [31:0] ins);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] res;
        logic [31:0] pc4;
        logic [31:0] br_target;
        logic [31:0] next_pc;
        logic        wr;
        rs = ins[25:21];
        rt = ins[20:16];
        a = regs[rs];
        b = regs[rt];
        se = {{16{ins[15]}}, ins[15:0]};
        ze = {16'h0000, ins[15:0]};
        pc4 = pc + 32'd4;
        br_target = pc4 + {se[29:0], 2'b00};
        next_pc = pc4;
        wr = 1'b1;
        dst = rt;
        res = 32'h0;
        case (ins[31:26])
            mips_pkg::op_special: begin
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::funct_addu: res = a + b;
                    mips_pkg::funct_subu: res = a - b;
                    mips_pkg::funct_and:  res = a & b;
                    mips_pkg::funct_or:   res = a | b;
                    mips_pkg::funct_xor:  res = a ^ b;
                    mips_pkg::funct_nor:  res = ~(a | b);
                    mips_pkg::funct_slt:  res = {31'd0, $signed(a) < $signed(b)};
                    mips_pkg::funct_sltu: res = {31'd0, a < b};
                    mips_pkg::funct_sll:  res = b << ins[10:6];
                    mips_pkg::funct_srl:  res = b >> ins[10:6];
                    mips_pkg::funct_sra:  res = $unsigned($signed(b) >>> ins[10:6]);
                    default:              wr = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: res = a + se;
            mips_pkg::op_slti:  res = {31'd0, $signed(a) < $signed(se)};
            mips_pkg::op_sltiu: res = {31'd0, a < se};
            mips_pkg::op_andi:  res = a & ze;
            mips_pkg::op_ori:   res = a | ze;
            mips_pkg::op_xori:  res = a ^ ze;
            mips_pkg::op_lui:   res = {ins[15:0], 16'h0000};
            default: begin
                wr = 1'b0;
                case (ins[31:26])
                    mips_pkg::op_beq:  next_pc = (a == b) ? br_target : pc4;
                    mips_pkg::op_bne:  next_pc = (a != b) ? br_target : pc4;
                    mips_pkg::op_bgtz: next_pc = ($signed(a) > 0) ? br_target : pc4;
                    mips_pkg::op_blez: next_pc = ($signed(a) <= 0) ? br_target : pc4;
                    mips_pkg::op_j:    next_pc = {pc4[31:28], ins[25:0], 2'b00};
                    default:           next_pc = pc4;
                endcase
            end
        endcase
        if (wr && (dst != 5'd0)) begin
            regs[dst] = res;
        end
        pc = next_pc;
    endtask

    initial begin
        error_count = 0;
        after_reset = 1'b0;
    end

    // the master still holds the request at the ack edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = 32'h0;
            end
            pc = reset_pc;
            after_reset = 1'b1;
        end else begin
            // ack must be low on the first edge after reset
            if (after_reset && (wb_ack !== 1'b0)) begin
                $display("error wb_ack got=%h exp=%h", wb_ack, 1'b0);
                error_count++;
            end
            after_reset = 1'b0;
            if (wb_ack && !(wb_cyc && wb_stb)) begin
                $display("ack seen without an active request at adr %h", wb_adr);
                error_count++;
            end else if (wb_ack && wb_we && (wb_adr == mips_pkg::adr_exec)) begin
                apply_instr(wb_dat_w);
            end else if (wb_ack && !wb_we) begin
                expected = read_model(wb_adr);
                if (wb_dat_r !== expected) begin
                    $display("error wb_dat_r adr=%h got=%h exp=%h", wb_adr, wb_dat_r,
                             expected);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mips_core.sv
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] reset_pc = 32'h0000_1000;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    int          check_errors;
    int          timeouts;
    int          tests;
    int          failed_tests;
    int          errors_before;
    logic [31:0] rng;

    logic [5:0] r_functs [11] = '{mips_pkg::funct_addu, mips_pkg::funct_subu,
        mips_pkg::funct_and, mips_pkg::funct_or, mips_pkg::funct_xor, mips_pkg::funct_nor,
        mips_pkg::funct_slt, mips_pkg::funct_sltu, mips_pkg::funct_sll,
        mips_pkg::funct_srl, mips_pkg::funct_sra};
    logic [5:0] i_ops [7] = '{mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
        mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
    logic [5:0] br_ops [5] = '{mips_pkg::op_beq, mips_pkg::op_bne, mips_pkg::op_bgtz,
        mips_pkg::op_blez, mips_pkg::op_j};
    // opcodes and functs outside the supported subset
    logic [5:0] bad_ops [8] = '{6'h01, 6'h03, 6'h08, 6'h10, 6'h20, 6'h23, 6'h2b, 6'h3f};
    logic [5:0] bad_functs [6] = '{6'h08, 6'h09, 6'h10, 6'h18, 6'h20, 6'h22};

    always #4 clk = ~clk;

    mips_core #(
        .reset_pc   (reset_pc)
    ) mips_core_inst (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    core_checker #(
        .reset_pc   (reset_pc)
    ) core_checker_inst (
        .clk            (clk),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .error_count    (check_errors)
    );

    function logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand32();
        return r[4:0];
    endfunction

    function logic [15:0] rand_imme();
        logic [31:0] r;
        r = rand32();
        return r[15:0];
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {mips_pkg::op_special, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imme);
        return {op, rs, rt, imme};
    endfunction

    // starts and ends 1 unit after a clock edge
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] data);
        bit ok;
        int cycles;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        ok = 1'b0;
        cycles = 0;
        while (!ok && (cycles < 20)) begin
            @(posedge clk);
            #1;
            ok = wb_ack;
            cycles++;
        end
        if (ok) begin
            @(posedge clk);
            #1;
        end else begin
            $display("no ack within 20 cycles for access to adr %h", adr);
            timeouts++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic issue(input logic [31:0] ins);
        bus_cycle(1'b1, mips_pkg::adr_exec, ins);
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 32; r++) begin
            bus_cycle(1'b0, r[7:0], 32'h0);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (check_errors + timeouts == errors_before) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: fail", tests, name);
        end
        errors_before = check_errors + timeouts;
    endtask

    initial begin
        logic [4:0]  rs;
        logic [7:0]  adr;
        logic [5:0]  op;
        clk = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 8'h00;
        wb_dat_w = 32'h0;
        timeouts = 0;
        tests = 0;
        failed_tests = 0;
        errors_before = 0;
        rng = 32'd94451;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        read_all_regs();
        bus_cycle(1'b0, mips_pkg::adr_pc, 32'h0);
        end_test("reset state");

        // fill registers with random values first
        for (int r = 1; r < 32; r++) begin
            issue(i_type(mips_pkg::op_lui, 5'd0, r[4:0], rand_imme()));
            issue(i_type(mips_pkg::op_ori, r[4:0], r[4:0], rand_imme()));
        end
        for (int i = 0; i < 60; i++) begin
            issue(r_type(r_functs[rand32() % 11], rand_reg(), rand_reg(), rand_reg(),
                         rand_reg()));
        end
        read_all_regs();
        end_test("r-type alu");

        for (int i = 0; i < 60; i++) begin
            issue(i_type(i_ops[rand32() % 7], rand_reg(), rand_reg(), rand_imme()));
        end
        read_all_regs();
        end_test("immediates");

        for (int i = 0; i < 8; i++) begin
            issue(r_type(r_functs[rand32() % 11], rand_reg(), rand_reg(), 5'd0, rand_reg()));
            issue(i_type(i_ops[rand32() % 7], rand_reg(), 5'd0, rand_imme()));
            issue({bad_ops[i], 26'd0} | (rand32() & 32'h03ff_ffff));
            issue(r_type(bad_functs[rand32() % 6], rand_reg(), rand_reg(), rand_reg(), 5'd0));
            adr = rand32() % 256;
            bus_cycle(1'b1, (adr == mips_pkg::adr_exec) ? 8'h41 : adr, rand32());
            bus_cycle(1'b0, mips_pkg::adr_pc, 32'h0);
        end
        read_all_regs();
        end_test("no-op writes");

        for (int i = 0; i < 40; i++) begin
            op = br_ops[rand32() % 5];
            rs = rand_reg();
            if (op == mips_pkg::op_j) begin
                issue({op, 26'd0} | (rand32() & 32'h03ff_ffff));
            end else begin
                // equal operands now and then so beq and bne go both ways
                issue(i_type(op, rs, (rand32() % 3 == 0) ? rs : rand_reg(), rand_imme()));
            end
            bus_cycle(1'b0, mips_pkg::adr_pc, 32'h0);
        end
        end_test("branches");

        for (int i = 0; i < 20; i++) begin
            adr = 8'h21 + (rand32() % 223);
            bus_cycle(1'b0, adr, 32'h0);
        end
        end_test("unmapped reads");

        $display("tests=%0d failed_tests=%0d errors=%0d", tests, failed_tests,
                 check_errors + timeouts);
        if ((failed_tests == 0) && (check_errors + timeouts == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
